// File: lce_params.svh
// instruction cache coherence engine geometry and id widths

`ifndef LCE_PARAMS_SVH
`define LCE_PARAMS_SVH

// cache geometry
`define LCE_SETS 64
`define LCE_ASSOC 8

// address split: tag | index | block offset
`define PADDR_WIDTH 32
`define BLOCK_WIDTH 128
`define BLOCK_OFFSET_WIDTH 4
`define INDEX_WIDTH 6
`define TAG_WIDTH 22
`define WAY_WIDTH 3

// each directory sends one sync before the engine is ready
`define NUM_CCE 2

// id widths on the coherence network
`define CCE_ID_WIDTH 2
`define LCE_ID_WIDTH 4

`endif

// File: lce_pkg.sv
// types, message encodings and packet formats of the icache coherence engine

`include "lce_params.svh"

package lce_pkg;

  typedef logic [`PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`INDEX_WIDTH-1:0] index_t;
  typedef logic [`TAG_WIDTH-1:0]   tag_t;
  typedef logic [`WAY_WIDTH-1:0]   way_t;
  typedef logic [`BLOCK_WIDTH-1:0] block_t;

  typedef enum logic [1:0] {
    e_coh_invalid   = 2'd0,
    e_coh_shared    = 2'd1,
    e_coh_exclusive = 2'd2,
    e_coh_modified  = 2'd3
  } coh_state_e;

  // commands from the directory
  typedef enum logic [2:0] {
    e_cmd_sync           = 3'd0,
    e_cmd_set_clear      = 3'd1,
    e_cmd_set_tag        = 3'd2,
    e_cmd_set_tag_wakeup = 3'd3,
    e_cmd_invalidate_tag = 3'd4,
    e_cmd_writeback      = 3'd5,
    e_cmd_data           = 3'd6
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack = 2'd0,
    e_resp_inv_ack  = 2'd1,
    e_resp_null_wb  = 2'd2
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_tag_set_clear  = 2'd0,
    e_tag_invalidate = 2'd1,
    e_tag_set_tag    = 2'd2
  } tag_op_e;

  typedef struct packed {
    lce_cmd_type_e             msg_type;
    logic [`CCE_ID_WIDTH-1:0]  src_id;
    way_t                      way_id;
    coh_state_e                state;
    paddr_t                    addr;
    block_t                    data;
  } lce_cmd_s;

  typedef struct packed {
    logic [`LCE_ID_WIDTH-1:0]  src_id;
    logic [`CCE_ID_WIDTH-1:0]  dst_id;
    lce_resp_type_e            msg_type;
    paddr_t                    addr;
  } lce_resp_s;

  typedef struct packed {
    tag_op_e    opcode;
    index_t     index;
    way_t       way_id;
    coh_state_e state;
    tag_t       tag;
  } tag_mem_pkt_s;

  // data fills always write a whole block
  typedef struct packed {
    index_t index;
    way_t   way_id;
    block_t data;
  } data_mem_pkt_s;

endpackage

// File: lce_init_sweep.sv
// reset sweep that clears the tag entry of every set once after reset

`timescale 1ns/1ps

`include "lce_params.svh"

module lce_init_sweep (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 sweep_ready_i,
  output lce_pkg::tag_mem_pkt_s sweep_pkt_o,
  output logic                 sweep_v_o,
  output logic                 sweep_done_o
);

  import lce_pkg::*;

  // one spare bit so an overrun would be visible
  localparam int CNT_WIDTH = `INDEX_WIDTH + 1;

  logic [CNT_WIDTH-1:0] set_cnt_r;
  logic                 done_r;
  logic                 last_set;

  // offer a clear only while the tag port can take it
  assign sweep_v_o = ~done_r & sweep_ready_i;
  assign last_set  = (set_cnt_r == CNT_WIDTH'(`LCE_SETS - 1));

  always_comb begin
    sweep_pkt_o        = '0;
    sweep_pkt_o.opcode = e_tag_set_clear;
    sweep_pkt_o.index  = set_cnt_r[`INDEX_WIDTH-1:0];
    sweep_pkt_o.state  = e_coh_invalid;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      set_cnt_r <= '0;
      done_r    <= 1'b0;
    end else if (sweep_v_o) begin
      set_cnt_r <= set_cnt_r + 1'b1;
      if (last_set) begin
        done_r <= 1'b1;
      end
    end
  end

  assign sweep_done_o = done_r;

  // the walk stops at the last set and never wraps into a second pass
  a_cnt_in_range : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !done_r |-> (set_cnt_r <= CNT_WIDTH'(`LCE_SETS - 1))
  ) else $error("sweep counter passed the last set");

endmodule

// File: lce_mem_arbiter.sv
// tag port arbiter giving the port to the reset sweep first and the command handler after

`timescale 1ns/1ps

module lce_mem_arbiter (
  input  lce_pkg::tag_mem_pkt_s sweep_pkt_i,
  input  logic                  sweep_v_i,
  input  logic                  sweep_done_i,
  output logic                  sweep_ready_o,

  input  lce_pkg::tag_mem_pkt_s cmd_pkt_i,
  input  logic                  cmd_v_i,
  output logic                  cmd_ready_o,

  output lce_pkg::tag_mem_pkt_s tag_mem_pkt_o,
  output logic                  tag_mem_pkt_v_o,
  input  logic                  tag_mem_pkt_ready_i
);

  import lce_pkg::*;

  tag_mem_pkt_s sel_pkt;
  logic         sel_v;

  // ownership never returns to the sweep since done is sticky
  always_comb begin
    if (sweep_done_i) begin
      sel_pkt = cmd_pkt_i;
      sel_v   = cmd_v_i;
    end else begin
      sel_pkt = sweep_pkt_i;
      sel_v   = sweep_v_i;
    end
  end

  assign tag_mem_pkt_o   = sel_pkt;
  assign tag_mem_pkt_v_o = sel_v;

  // only the owner sees the memory ready
  assign sweep_ready_o = ~sweep_done_i & tag_mem_pkt_ready_i;
  assign cmd_ready_o   = sweep_done_i & tag_mem_pkt_ready_i;

  // a handler packet before done would be dropped silently
  always_comb begin
    a_no_cmd_before_done : assert (!(cmd_v_i && (sweep_done_i == 1'b0)))
      else $error("command packet offered during the reset sweep");
  end

endmodule

// File: lce_cmd_handler.sv
// command decoder of the icache coherence engine with reset, sync and ready modes

`timescale 1ns/1ps

`include "lce_params.svh"

module lce_cmd_handler (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [`LCE_ID_WIDTH-1:0]  lce_id_i,
  input  lce_pkg::paddr_t           miss_addr_i,
  input  logic                      sweep_done_i,

  input  lce_pkg::lce_cmd_s         lce_cmd_i,
  input  logic                      lce_cmd_v_i,
  output logic                      lce_cmd_yumi_o,

  output lce_pkg::tag_mem_pkt_s     cmd_pkt_o,
  output logic                      cmd_v_o,
  input  logic                      tag_ready_i,

  output lce_pkg::data_mem_pkt_s    data_mem_pkt_o,
  output logic                      data_mem_pkt_v_o,
  input  logic                      data_mem_pkt_ready_i,

  output lce_pkg::lce_resp_s        lce_resp_o,
  output logic                      lce_resp_v_o,
  input  logic                      lce_resp_yumi_i,

  output logic                      lce_ready_o,
  output logic                      set_tag_received_o,
  output logic                      set_tag_wakeup_received_o,
  output logic                      cce_data_received_o,
  output logic                      cache_req_complete_o
);

  import lce_pkg::*;

  localparam int SYNC_CNT_WIDTH = $clog2(`NUM_CCE + 1);

  typedef enum logic [1:0] {
    e_mode_reset         = 2'd0,
    e_mode_uncached_only = 2'd1,
    e_mode_ready         = 2'd2
  } lce_mode_e;

  lce_mode_e                 mode_r, mode_n;
  logic [SYNC_CNT_WIDTH-1:0] sync_cnt_r, sync_cnt_n;
  logic                      inv_flag_r, inv_flag_n;

  index_t cmd_index;
  tag_t   cmd_tag;
  index_t miss_index;
  logic   resp_take;

  function automatic tag_mem_pkt_s build_tag_pkt(
    input tag_op_e    op,
    input index_t     idx,
    input way_t       way,
    input coh_state_e st,
    input tag_t       tag
  );
    tag_mem_pkt_s pkt;
    pkt.opcode = op;
    pkt.index  = idx;
    pkt.way_id = way;
    pkt.state  = st;
    pkt.tag    = tag;
    return pkt;
  endfunction

  assign cmd_index  = lce_cmd_i.addr[`BLOCK_OFFSET_WIDTH +: `INDEX_WIDTH];
  assign cmd_tag    = lce_cmd_i.addr[`BLOCK_OFFSET_WIDTH + `INDEX_WIDTH +: `TAG_WIDTH];
  assign miss_index = miss_addr_i[`BLOCK_OFFSET_WIDTH +: `INDEX_WIDTH];
  assign resp_take  = lce_resp_v_o & lce_resp_yumi_i;

  // ready follows the sticky done flag a cycle ahead of the mode register
  assign lce_ready_o = sweep_done_i;

  always_comb begin
    mode_n     = mode_r;
    sync_cnt_n = sync_cnt_r;
    inv_flag_n = inv_flag_r;

    lce_cmd_yumi_o   = 1'b0;
    cmd_pkt_o        = '0;
    cmd_v_o          = 1'b0;
    data_mem_pkt_o   = '0;
    data_mem_pkt_v_o = 1'b0;

    lce_resp_o          = '0;
    lce_resp_o.src_id   = lce_id_i;
    lce_resp_o.dst_id   = lce_cmd_i.src_id;
    lce_resp_o.addr     = lce_cmd_i.addr;
    lce_resp_v_o        = 1'b0;

    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o       = 1'b0;
    cache_req_complete_o      = 1'b0;

    case (mode_r)
      e_mode_reset: begin
        if (sweep_done_i) begin
          mode_n = e_mode_uncached_only;
        end
      end

      e_mode_uncached_only: begin
        if (lce_cmd_i.msg_type == e_cmd_set_clear) begin
          cmd_pkt_o = build_tag_pkt(e_tag_set_clear, cmd_index, '0, e_coh_invalid, '0);
          cmd_v_o        = lce_cmd_v_i & tag_ready_i;
          lce_cmd_yumi_o = cmd_v_o;
        end else if (lce_cmd_i.msg_type == e_cmd_sync) begin
          lce_resp_o.msg_type = e_resp_sync_ack;
          lce_resp_o.addr     = '0;
          lce_resp_v_o        = lce_cmd_v_i;
          lce_cmd_yumi_o      = resp_take;
          // last directory synced, leave for ready
          if (resp_take) begin
            if (sync_cnt_r == SYNC_CNT_WIDTH'(`NUM_CCE - 1)) begin
              mode_n     = e_mode_ready;
              sync_cnt_n = '0;
            end else begin
              sync_cnt_n = sync_cnt_r + 1'b1;
            end
          end
        end
      end

      e_mode_ready: begin
        case (lce_cmd_i.msg_type)
          e_cmd_writeback: begin
            lce_resp_o.msg_type = e_resp_null_wb;
            lce_resp_v_o        = lce_cmd_v_i;
            lce_cmd_yumi_o      = resp_take;
          end

          e_cmd_set_tag, e_cmd_set_tag_wakeup: begin
            cmd_pkt_o = build_tag_pkt(e_tag_set_tag, cmd_index, lce_cmd_i.way_id,
                                      lce_cmd_i.state, cmd_tag);
            cmd_v_o        = lce_cmd_v_i & tag_ready_i;
            lce_cmd_yumi_o = cmd_v_o;
            if (lce_cmd_i.msg_type == e_cmd_set_tag) begin
              set_tag_received_o = cmd_v_o;
            end else begin
              set_tag_wakeup_received_o = cmd_v_o;
              cache_req_complete_o      = cmd_v_o;
            end
          end

          e_cmd_invalidate_tag: begin
            cmd_pkt_o = build_tag_pkt(e_tag_invalidate, cmd_index, lce_cmd_i.way_id,
                                      e_coh_invalid, '0);
            // tag write goes out once, the flag then holds the ack
            cmd_v_o             = lce_cmd_v_i & tag_ready_i & ~inv_flag_r;
            lce_resp_o.msg_type = e_resp_inv_ack;
            lce_resp_v_o        = inv_flag_r | cmd_v_o;
            lce_cmd_yumi_o      = resp_take;
            inv_flag_n          = ~resp_take & (inv_flag_r | cmd_v_o);
          end

          e_cmd_data: begin
            // fill lands in the set of the outstanding miss
            cmd_pkt_o = build_tag_pkt(e_tag_set_tag, miss_index, lce_cmd_i.way_id,
                                      lce_cmd_i.state, cmd_tag);
            data_mem_pkt_o.index  = miss_index;
            data_mem_pkt_o.way_id = lce_cmd_i.way_id;
            data_mem_pkt_o.data   = lce_cmd_i.data;
            cmd_v_o          = lce_cmd_v_i & tag_ready_i & data_mem_pkt_ready_i;
            data_mem_pkt_v_o = cmd_v_o;
            lce_cmd_yumi_o       = cmd_v_o;
            cce_data_received_o  = cmd_v_o;
            set_tag_received_o   = cmd_v_o;
            cache_req_complete_o = cmd_v_o;
          end

          e_cmd_set_clear: begin
            cmd_pkt_o = build_tag_pkt(e_tag_set_clear, cmd_index, '0, e_coh_invalid, '0);
            cmd_v_o        = lce_cmd_v_i & tag_ready_i;
            lce_cmd_yumi_o = cmd_v_o;
          end

          default: begin
          end
        endcase
      end

      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r     <= e_mode_reset;
      sync_cnt_r <= '0;
      inv_flag_r <= 1'b0;
    end else begin
      mode_r     <= mode_n;
      sync_cnt_r <= sync_cnt_n;
      inv_flag_r <= inv_flag_n;
    end
  end

  a_yumi_needs_valid : assert property (
    @(posedge clk_i) disable iff (reset_i)
    lce_cmd_yumi_o |-> lce_cmd_v_i
  ) else $error("command consumed without a valid command");

  a_fill_only_when_ready : assert property (
    @(posedge clk_i) disable iff (reset_i)
    data_mem_pkt_v_o |-> (mode_r == e_mode_ready)
  ) else $error("data fill issued outside ready mode");

endmodule

// File: icache_lce_cmd.sv
// icache coherence engine command side, joining sweep, handler and tag port arbiter

`timescale 1ns/1ps

`include "lce_params.svh"

module icache_lce_cmd (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [`LCE_ID_WIDTH-1:0]  lce_id_i,
  input  lce_pkg::paddr_t           miss_addr_i,

  input  lce_pkg::lce_cmd_s         lce_cmd_i,
  input  logic                      lce_cmd_v_i,
  output logic                      lce_cmd_yumi_o,

  output lce_pkg::tag_mem_pkt_s     tag_mem_pkt_o,
  output logic                      tag_mem_pkt_v_o,
  input  logic                      tag_mem_pkt_ready_i,

  output lce_pkg::data_mem_pkt_s    data_mem_pkt_o,
  output logic                      data_mem_pkt_v_o,
  input  logic                      data_mem_pkt_ready_i,

  output lce_pkg::lce_resp_s        lce_resp_o,
  output logic                      lce_resp_v_o,
  input  logic                      lce_resp_yumi_i,

  output logic                      lce_ready_o,
  output logic                      set_tag_received_o,
  output logic                      set_tag_wakeup_received_o,
  output logic                      cce_data_received_o,
  output logic                      cache_req_complete_o
);

  import lce_pkg::*;

  tag_mem_pkt_s sweep_pkt;
  logic         sweep_v;
  logic         sweep_ready;
  logic         sweep_done;

  tag_mem_pkt_s cmd_pkt;
  logic         cmd_v;
  logic         cmd_ready;

  lce_init_sweep sweep_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .sweep_ready_i (sweep_ready),
    .sweep_pkt_o   (sweep_pkt),
    .sweep_v_o     (sweep_v),
    .sweep_done_o  (sweep_done)
  );

  lce_cmd_handler handler_i (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id_i),
    .miss_addr_i               (miss_addr_i),
    .sweep_done_i              (sweep_done),
    .lce_cmd_i                 (lce_cmd_i),
    .lce_cmd_v_i               (lce_cmd_v_i),
    .lce_cmd_yumi_o            (lce_cmd_yumi_o),
    .cmd_pkt_o                 (cmd_pkt),
    .cmd_v_o                   (cmd_v),
    .tag_ready_i               (cmd_ready),
    .data_mem_pkt_o            (data_mem_pkt_o),
    .data_mem_pkt_v_o          (data_mem_pkt_v_o),
    .data_mem_pkt_ready_i      (data_mem_pkt_ready_i),
    .lce_resp_o                (lce_resp_o),
    .lce_resp_v_o              (lce_resp_v_o),
    .lce_resp_yumi_i           (lce_resp_yumi_i),
    .lce_ready_o               (lce_ready_o),
    .set_tag_received_o        (set_tag_received_o),
    .set_tag_wakeup_received_o (set_tag_wakeup_received_o),
    .cce_data_received_o       (cce_data_received_o),
    .cache_req_complete_o      (cache_req_complete_o)
  );

  lce_mem_arbiter arbiter_i (
    .sweep_pkt_i         (sweep_pkt),
    .sweep_v_i           (sweep_v),
    .sweep_done_i        (sweep_done),
    .sweep_ready_o       (sweep_ready),
    .cmd_pkt_i           (cmd_pkt),
    .cmd_v_i             (cmd_v),
    .cmd_ready_o         (cmd_ready),
    .tag_mem_pkt_o       (tag_mem_pkt_o),
    .tag_mem_pkt_v_o     (tag_mem_pkt_v_o),
    .tag_mem_pkt_ready_i (tag_mem_pkt_ready_i)
  );

endmodule

// File: tb_icache_lce_cmd.sv
// testbench for the icache coherence engine command side, driven from a data file

`timescale 1ns/1ps

`include "lce_params.svh"

module tb_icache_lce_cmd;

  import lce_pkg::*;

  localparam int HALF_PERIOD  = 20;
  localparam int SAMPLE_DELAY = 10;
  localparam int TIMEOUT      = 200;
  localparam int HOLD_CYCLES  = 8;
  localparam logic [`LCE_ID_WIDTH-1:0] LCE_ID = 4'h9;

  logic                     clk_i;
  logic                     reset_i;
  logic [`LCE_ID_WIDTH-1:0] lce_id_i;
  paddr_t                   miss_addr_i;
  lce_cmd_s                 lce_cmd_i;
  logic                     lce_cmd_v_i;
  logic                     lce_cmd_yumi_o;
  tag_mem_pkt_s             tag_mem_pkt_o;
  logic                     tag_mem_pkt_v_o;
  logic                     tag_mem_pkt_ready_i;
  data_mem_pkt_s            data_mem_pkt_o;
  logic                     data_mem_pkt_v_o;
  logic                     data_mem_pkt_ready_i;
  lce_resp_s                lce_resp_o;
  logic                     lce_resp_v_o;
  logic                     lce_resp_yumi_i;
  logic                     lce_ready_o;
  // set_tag, wakeup, cce_data, req_complete
  logic [3:0]               pulses;

  logic [31:0]   lfsr_state;
  string         test_name;
  logic          exp_tag_v;
  logic          exp_data_v;
  logic          exp_resp_v;
  tag_mem_pkt_s  exp_tag;
  data_mem_pkt_s exp_data;
  lce_resp_s     exp_resp;
  logic [3:0]    exp_pulses;
  logic          tag_seen;
  logic          data_seen;
  logic          resp_seen;
  logic [3:0]    pulses_seen;

  icache_lce_cmd dut_i (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id_i),
    .miss_addr_i               (miss_addr_i),
    .lce_cmd_i                 (lce_cmd_i),
    .lce_cmd_v_i               (lce_cmd_v_i),
    .lce_cmd_yumi_o            (lce_cmd_yumi_o),
    .tag_mem_pkt_o             (tag_mem_pkt_o),
    .tag_mem_pkt_v_o           (tag_mem_pkt_v_o),
    .tag_mem_pkt_ready_i       (tag_mem_pkt_ready_i),
    .data_mem_pkt_o            (data_mem_pkt_o),
    .data_mem_pkt_v_o          (data_mem_pkt_v_o),
    .data_mem_pkt_ready_i      (data_mem_pkt_ready_i),
    .lce_resp_o                (lce_resp_o),
    .lce_resp_v_o              (lce_resp_v_o),
    .lce_resp_yumi_i           (lce_resp_yumi_i),
    .lce_ready_o               (lce_ready_o),
    .set_tag_received_o        (pulses[3]),
    .set_tag_wakeup_received_o (pulses[2]),
    .cce_data_received_o       (pulses[1]),
    .cache_req_complete_o      (pulses[0])
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("Error: test %s, %s", test_name, why);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_tag_pkt(input string what, input tag_mem_pkt_s exp,
                               input tag_mem_pkt_s act);
    if (act !== exp) abort_run($sformatf("%s expected %h actual %h", what, exp, act));
  endtask

  task automatic verify_data_pkt(input string what, input data_mem_pkt_s exp,
                                 input data_mem_pkt_s act);
    if (act !== exp) abort_run($sformatf("%s expected %h actual %h", what, exp, act));
  endtask

  task automatic compare_resp(input string what, input lce_resp_s exp, input lce_resp_s act);
    if (act !== exp) abort_run($sformatf("%s expected %h actual %h", what, exp, act));
  endtask

  task automatic expect_bit(input string what, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("%s expected %b actual %b", what, exp, act));
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic sweep_sets();
    tag_mem_pkt_s exp;
    int           idx;
    int           cycles;
    idx = 0;
    cycles = 0;
    exp = '0;
    exp.opcode = e_tag_set_clear;
    exp.state = e_coh_invalid;
    while (idx < `LCE_SETS) begin
      @(negedge clk_i);
      draw_bit(tag_mem_pkt_ready_i);
      #SAMPLE_DELAY;
      expect_bit("ready during sweep", 1'b0, lce_ready_o);
      expect_bit("clear offered with ready", tag_mem_pkt_ready_i, tag_mem_pkt_v_o);
      if (tag_mem_pkt_v_o && tag_mem_pkt_ready_i) begin
        exp.index = index_t'(idx);
        check_tag_pkt("clear packet", exp, tag_mem_pkt_o);
        idx++;
      end
      cycles++;
      if (idx < `LCE_SETS && cycles >= 8 * `LCE_SETS) abort_run("reset sweep did not finish");
    end
    @(negedge clk_i);
    tag_mem_pkt_ready_i = 1'b1;
    #SAMPLE_DELAY;
    expect_bit("ready after sweep", 1'b1, lce_ready_o);
    expect_bit("tag port idle after sweep", 1'b0, tag_mem_pkt_v_o);
  endtask

  // one sample point per cycle, between the falling and the rising edge
  task automatic watch_outputs();
    if (tag_mem_pkt_v_o && tag_mem_pkt_ready_i) begin
      if (tag_seen || !exp_tag_v) abort_run("unexpected or repeated tag packet");
      check_tag_pkt("tag packet", exp_tag, tag_mem_pkt_o);
      tag_seen = 1'b1;
    end
    if (data_mem_pkt_v_o && data_mem_pkt_ready_i) begin
      if (data_seen || !exp_data_v) abort_run("unexpected or repeated data packet");
      verify_data_pkt("data packet", exp_data, data_mem_pkt_o);
      expect_bit("tag write with data", 1'b1, tag_mem_pkt_v_o & tag_mem_pkt_ready_i);
      data_seen = 1'b1;
    end
    if (lce_resp_v_o) begin
      if (resp_seen || !exp_resp_v) abort_run("unexpected or repeated response");
      compare_resp("response", exp_resp, lce_resp_o);
      resp_seen = lce_resp_yumi_i;
    end
    if ((pulses & pulses_seen) != 4'h0) abort_run("a status pulse fired twice");
    pulses_seen = pulses_seen | pulses;
  endtask

  task automatic apply_line(input string line);
    string    name;
    logic     consume;
    logic [2:0] c_type;
    logic [`CCE_ID_WIDTH-1:0] c_src;
    way_t     c_way;
    logic [1:0] c_state;
    paddr_t   c_addr;
    block_t   c_data;
    paddr_t   c_miss;
    logic [1:0] t_op;
    index_t   t_idx;
    way_t     t_way;
    logic [1:0] t_st;
    tag_t     t_tag;
    index_t   d_idx;
    logic [1:0] r_type;
    paddr_t   r_addr;
    int       n;
    int       cycles;
    logic     stop;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, consume, c_type, c_src, c_way, c_state, c_addr, c_data, c_miss,
                exp_tag_v, t_op, t_idx, t_way, t_st, t_tag, exp_data_v, d_idx,
                exp_resp_v, r_type, r_addr, exp_pulses);
    test_name = name;
    if (n != 21) abort_run("malformed line in the data file");
    exp_tag.opcode = tag_op_e'(t_op);
    exp_tag.index = t_idx;
    exp_tag.way_id = t_way;
    exp_tag.state = coh_state_e'(t_st);
    exp_tag.tag = t_tag;
    exp_data.index = d_idx;
    exp_data.way_id = c_way;
    exp_data.data = c_data;
    exp_resp.src_id = LCE_ID;
    exp_resp.dst_id = c_src;
    exp_resp.msg_type = lce_resp_type_e'(r_type);
    exp_resp.addr = r_addr;
    tag_seen = 1'b0;
    data_seen = 1'b0;
    resp_seen = 1'b0;
    pulses_seen = 4'h0;
    cycles = 0;
    stop = 1'b0;
    while (!stop) begin
      @(negedge clk_i);
      lce_cmd_i.msg_type = lce_cmd_type_e'(c_type);
      lce_cmd_i.src_id = c_src;
      lce_cmd_i.way_id = c_way;
      lce_cmd_i.state = coh_state_e'(c_state);
      lce_cmd_i.addr = c_addr;
      lce_cmd_i.data = c_data;
      miss_addr_i = c_miss;
      lce_cmd_v_i = 1'b1;
      draw_bit(tag_mem_pkt_ready_i);
      draw_bit(data_mem_pkt_ready_i);
      draw_bit(lce_resp_yumi_i);
      #SAMPLE_DELAY;
      watch_outputs();
      cycles++;
      if (consume) begin
        stop = lce_cmd_yumi_o;
        if (!stop && cycles >= TIMEOUT) abort_run("command was not consumed in time");
      end else begin
        expect_bit("command held back", 1'b0, lce_cmd_yumi_o);
        stop = (cycles >= HOLD_CYCLES);
      end
    end
    @(negedge clk_i);
    lce_cmd_v_i = 1'b0;
    expect_bit("tag packet sent", exp_tag_v, tag_seen);
    expect_bit("data packet sent", exp_data_v, data_seen);
    expect_bit("response taken", exp_resp_v, resp_seen);
    for (int i = 0; i < 4; i++) begin
      expect_bit($sformatf("status pulse %0d", i), exp_pulses[i], pulses_seen[i]);
    end
  endtask

  initial begin
    int    fd;
    int    code;
    int    lines_run;
    string line;
    lfsr_state = 32'hd530_5493;
    test_name = "reset_sweep";
    lines_run = 0;
    reset_i = 1'b1;
    lce_id_i = LCE_ID;
    miss_addr_i = '0;
    lce_cmd_i = '0;
    lce_cmd_v_i = 1'b0;
    tag_mem_pkt_ready_i = 1'b0;
    data_mem_pkt_ready_i = 1'b0;
    lce_resp_yumi_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    sweep_sets();
    fd = $fopen("lce_testdata.txt", "r");
    if (fd == 0) abort_run("cannot open lce_testdata.txt");
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        apply_line(line);
        lines_run++;
      end
    end
    $fclose(fd);
    if (lines_run == 0) begin
      abort_run("no commands found in the data file");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: icache_lce_cmd.f
+incdir+.
lce_pkg.sv
lce_init_sweep.sv
lce_mem_arbiter.sv
lce_cmd_handler.sv
icache_lce_cmd.sv
tb_icache_lce_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_icache_lce_cmd \
  -f icache_lce_cmd.f \
  -o tb_icache_lce_cmd

./obj_dir/tb_icache_lce_cmd 2>&1 | tee sim.log

if grep -qF 'All tests passed!' sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED"
  exit 1
fi

// File: lce_testdata.txt
# name consume type src way state addr data miss | tag: v op idx way st tag | data: v idx
# resp: v type addr | pulses (set_tag wakeup cce_data req_complete), encodings of lce_pkg, hex
sync_first 1 0 1 0 0 00000000 0 00000000 0 0 00 0 0 000000 0 00 1 0 00000000 0
early_set_clear 1 1 2 4 2 00000050 0 00000000 1 0 05 0 0 000000 0 00 0 0 00000000 0
early_set_tag 0 2 0 3 1 048d1558 0 00000000 0 0 00 0 0 000000 0 00 0 0 00000000 0
sync_second 1 0 2 0 0 00000000 0 00000000 0 0 00 0 0 000000 0 00 1 0 00000000 0
set_tag_shared 1 2 0 3 1 048d1558 0 00000000 1 2 15 3 1 012345 0 00 0 0 00000000 8
set_tag_wakeup 1 3 1 6 2 fffffff0 0 00000000 1 2 3f 6 2 3fffff 0 00 0 0 00000000 5
invalidate_a 1 4 1 5 3 002af2a4 0 00000000 1 1 2a 5 0 000000 0 00 1 1 002af2a4 0
invalidate_b 1 4 2 0 1 07c03c10 0 00000000 1 1 01 0 0 000000 0 00 1 1 07c03c10 0
fill_a 1 6 0 7 3 555554c0 0123456789abcdeffedcba9876543210 00000270 1 2 27 7 3 155555 1 27 0 0 0 b
writeback_a 1 5 1 2 0 12345678 0 00000000 0 0 00 0 0 000000 0 00 1 2 12345678 0
set_clear_a 1 1 2 4 2 03c3c33c 0 00000000 1 0 33 0 0 000000 0 00 0 0 00000000 0
set_tag_mod 1 2 1 0 3 abcdef12 0 00000000 1 2 31 0 3 2af37b 0 00 0 0 00000000 8
invalidate_c 1 4 0 3 2 abcdef12 0 00000000 1 1 31 3 0 000000 0 00 1 1 abcdef12 0
fill_b 1 6 2 1 1 000007f0 ffff0000aaaa5555123400009876fedc deadbe0c 1 2 20 1 1 000001 1 20 0 0 0 b
writeback_b 1 5 2 6 1 0000fff0 0 00000000 0 0 00 0 0 000000 0 00 1 2 0000fff0 0
set_tag_wakeup_b 1 3 0 2 1 048d1558 0 00000000 1 2 15 2 1 012345 0 00 0 0 00000000 5
